// File: filelist.f
hdl/exe_pkg.sv
hdl/mul_stage_if.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/mul_front.sv
hdl/mul_back.sv
hdl/divider.sv
hdl/forward_unit.sv
hdl/exe.sv
verification/exe_tb.sv

// File: Bender.yml
package:
  name: exe

sources:
  - hdl/exe_pkg.sv
  - hdl/mul_stage_if.sv
  - hdl/alu.sv
  - hdl/branch_unit.sv
  - hdl/mul_front.sv
  - hdl/mul_back.sv
  - hdl/divider.sv
  - hdl/forward_unit.sv
  - hdl/exe.sv
  - target: simulation
    files:
      - verification/exe_tb.sv

// File: verification/exe_tb.sv
`timescale 1ns/1ns
module exe_tb;
    import exe_pkg::*;

    // issue slots summed over the test sections
    localparam int N_ISSUE    = 12 * 4 + 2 * 8 + 2 + 9 * 3 + 5 + 2 * 5 * 4 * 2;
    localparam int TIMEOUT_NS = (8 + 200 * N_ISSUE) * 100;

    logic clk, rstn;
    logic eu0_en, eu1_en;
    uop_t eu0_uop, eu1_uop;
    reg_addr_t eu0_rd, eu0_rj, eu0_rk, eu1_rd, eu1_rj, eu1_rk;
    word_t eu0_imm, eu0_pc, eu0_pc_next, data00, data01, data10, data11;
    logic stall, flush, branch_valid, branch_taken, en_out0, en_out1;
    word_t branch_pc, branch_target, data_out0, data_out1;
    reg_addr_t addr_out0, addr_out1;

    word_t arch[32];       // program-order register state
    word_t rf[32];         // register file copy that only write-backs update
    logic [36:0] q0[$];    // expected {addr, data} per lane
    logic [36:0] q1[$];
    logic      wb0_pend = 1'b0;    // write-back waiting for the next edge
    logic      wb1_pend = 1'b0;
    reg_addr_t wb0_addr;
    reg_addr_t wb1_addr;
    word_t     wb0_data;
    word_t     wb1_data;
    integer seed = 32'h12b3;
    int mismatches = 0;
    int other_errors = 0;

    exe exe_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic uop_t make_uop(itype_t t, logic [3:0] f, logic sel, logic us);
        return {3'b000, us, sel, f, t};
    endfunction

    function automatic reg_addr_t pick_reg_not(reg_addr_t avoid);
        reg_addr_t r;
        r = $random(seed);
        while (r == avoid || r == 5'd0) r = $random(seed);
        return r;
    endfunction

    function automatic word_t alu_model(logic [3:0] op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_NOR:  return ~(a | b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return (a >> b[4:0]) | (~(32'hffff_ffff >> b[4:0]) & {32{a[31]}});
            ALU_LUI:  return b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_model(logic [3:0] cond, word_t a, word_t b);
        case (cond)
            JIRL, B, BL: return 1'b1;
            BEQ:  return a == b;
            BNE:  return a != b;
            BLT:  return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
            BGE:  return (a ^ 32'h8000_0000) >= (b ^ 32'h8000_0000);
            BLTU: return a < b;
            BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // lane 0 write-back value for any unit type
    function automatic word_t lane0_model(uop_t uop, word_t a, word_t b, word_t pc);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0] prod;
        logic sel;
        logic us;
        sel = uop[UOP_MD_SEL];
        us  = uop[UOP_USIGN];
        sa  = us ? {32'd0, a} : {{32{a[31]}}, a};
        sb  = us ? {32'd0, b} : {{32{b[31]}}, b};
        case (uop[UOP_TYPE_LSB +: 3])
            ITYPE_ALU: return alu_model(uop[UOP_FUNC_LSB +: 4], a, b);
            ITYPE_MUL: begin
                prod = sa * sb;
                return sel ? prod[63:32] : prod[31:0];
            end
            ITYPE_DIV: begin
                if (b == '0) return sel ? a : 32'hffff_ffff;
                prod = sel ? sa % sb : sa / sb;    // 64 bits avoid the min/-1 overflow
                return prod[31:0];
            end
            default: return pc + 32'd4;    // link value
        endcase
    endfunction

    task automatic check_value(string what, word_t got, word_t exp);
        assert (got === exp) else begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic issue(input logic en0, input uop_t uop0, input reg_addr_t rd0, rj0, rk0,
                         input word_t imm0, input logic imm_src, input word_t pc, pcn,
                         input logic en1, input uop_t uop1, input reg_addr_t rd1, rj1, rk1);
        reg_addr_t src1;
        reg_addr_t dest;
        word_t a0, b0, res, tgt;
        logic is_br, tk, accepted;
        is_br = uop0[UOP_TYPE_LSB +: 3] == ITYPE_BR;
        src1 = is_br ? rd0 : rk0;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            eu0_en      = en0;
            eu0_uop     = uop0;
            eu0_rd      = rd0;
            eu0_rj      = rj0;
            eu0_rk      = rk0;
            eu0_imm     = imm0;
            eu0_pc      = pc;
            eu0_pc_next = pcn;
            eu1_en      = en1;
            eu1_uop     = uop1;
            eu1_rd      = rd1;
            eu1_rj      = rj1;
            eu1_rk      = rk1;
            data00 = rf[rj0];
            data01 = imm_src ? imm0 : rf[src1];
            data10 = rf[rj1];
            data11 = rf[rk1];
            #40;
            accepted = !stall;
        end
        a0 = arch[rj0];
        b0 = imm_src ? imm0 : arch[src1];
        if (en0 && is_br) begin
            tk  = branch_model(uop0[UOP_FUNC_LSB +: 4], a0, b0);
            tgt = (uop0[UOP_FUNC_LSB +: 4] == JIRL) ? a0 + imm0 : pc + imm0;
            check_value("branch_valid", {31'd0, branch_valid}, 32'd1);
            check_value("branch_pc", branch_pc, pc);
            check_value("branch_taken", {31'd0, branch_taken}, {31'd0, tk});
            check_value("branch_target", branch_target, tgt);
            check_value("flush", {31'd0, flush}, {31'd0, tk && tgt != pcn});
        end else begin
            check_value("branch_valid", {31'd0, branch_valid}, 32'd0);
        end
        if (en1) begin
            res = alu_model(uop1[UOP_FUNC_LSB +: 4], arch[rj1], arch[rk1]);
            if (rd1 != '0) q1.push_back({rd1, res});
        end
        if (en0) begin
            dest = rd0;
            if (is_br && uop0[UOP_FUNC_LSB +: 4] == BL) dest = 5'd1;
            else if (is_br && uop0[UOP_FUNC_LSB +: 4] != JIRL) dest = 5'd0;
            if (dest != '0) begin
                arch[dest] = lane0_model(uop0, a0, b0, pc);
                q0.push_back({dest, arch[dest]});
            end
        end
        if (en1 && rd1 != '0) arch[rd1] = res;
    endtask

    task automatic alu0(logic [3:0] op, reg_addr_t rd, rj, rk);
        issue(1'b1, make_uop(ITYPE_ALU, op, 1'b0, 1'b0), rd, rj, rk, '0, 1'b0, '0, '0,
              1'b0, '0, '0, '0, '0);
    endtask

    // outputs have settled 10 ns after the edge
    always @(posedge clk) begin
        logic [36:0] exp;
        #10;
        // register file write lands on the edge after its strobe
        if (wb0_pend) begin
            rf[wb0_addr] = wb0_data;
        end
        if (wb1_pend) begin
            rf[wb1_addr] = wb1_data;
        end
        if (en_out0) begin
            assert (q0.size() != 0) else begin
                $display("Unexpected lane 0 write-back at %0t", $time);
                other_errors++;
            end
            if (q0.size() != 0) begin
                exp = q0.pop_front();
                assert ({addr_out0, data_out0} === exp) else begin
                    $display("Mismatch at %0t: lane 0 wrote r%0d=%h expected r%0d=%h",
                             $time, addr_out0, data_out0, exp[36:32], exp[31:0]);
                    mismatches++;
                end
            end
        end
        if (en_out1) begin
            assert (q1.size() != 0) else begin
                $display("Unexpected lane 1 write-back at %0t", $time);
                other_errors++;
            end
            if (q1.size() != 0) begin
                exp = q1.pop_front();
                assert ({addr_out1, data_out1} === exp) else begin
                    $display("Mismatch at %0t: lane 1 wrote r%0d=%h expected r%0d=%h",
                             $time, addr_out1, data_out1, exp[36:32], exp[31:0]);
                    mismatches++;
                end
            end
        end
        wb0_pend = en_out0;
        wb0_addr = addr_out0;
        wb0_data = data_out0;
        wb1_pend = en_out1;
        wb1_addr = addr_out1;
        wb1_data = data_out1;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before all write-backs came back");
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        reg_addr_t rd0, rd1, ra, rb;
        word_t pc, imm;
        br_cond_t conds[9];
        word_t corners[5];
        reg_addr_t ma[5];
        reg_addr_t mb[5];
        reg_addr_t da[5];
        reg_addr_t db[5];
        conds   = '{JIRL, B, BL, BEQ, BNE, BLT, BGE, BLTU, BGEU};
        corners = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h1, 32'h0};
        ma = '{5'd20, 5'd20, 5'd21, 5'd22, 5'd23};
        mb = '{5'd20, 5'd21, 5'd22, 5'd22, 5'd2};
        da = '{5'd20, 5'd22, 5'd23, 5'd21, 5'd3};
        db = '{5'd21, 5'd24, 5'd24, 5'd20, 5'd4};
        rstn = 1'b0;
        eu0_en      = 0;
        eu0_uop     = '0;
        eu0_rd      = '0;
        eu0_rj      = '0;
        eu0_rk      = '0;
        eu0_imm     = '0;
        eu0_pc      = '0;
        eu0_pc_next = '0;
        data00      = '0;
        data01      = '0;
        eu1_en      = 0;
        eu1_uop     = '0;
        eu1_rd      = '0;
        eu1_rj      = '0;
        eu1_rk      = '0;
        data10      = '0;
        data11      = '0;
        arch[0] = '0;
        rf[0]   = '0;
        for (int i = 1; i < 32; i++) begin
            arch[i] = $random(seed);
            rf[i]   = arch[i];
        end
        repeat (8) @(negedge clk);
        rstn = 1'b1;
        #10;
        assert (!stall && !flush && !branch_valid && !en_out0 && !en_out1) else begin
            $display("Control outputs not low after reset");
            other_errors++;
        end

        // ALU ops on both lanes
        for (int op = 0; op < 12; op++) begin
            for (int n = 0; n < 4; n++) begin
                rd0 = $random(seed);    // may be r0 which is dropped
                rd1 = pick_reg_not(rd0);
                issue(1'b1, make_uop(ITYPE_ALU, op, 0, 0), rd0, $random(seed), $random(seed),
                      '0, 1'b0, '0, '0, 1'b1, make_uop(ITYPE_ALU, (op + 5) % 12, 0, 0),
                      rd1, pick_reg_not(rd0), pick_reg_not(rd0));
            end
        end

        // dependence chains at distance 1 and 2
        for (int i = 0; i < 8; i++) begin
            issue(1'b1, make_uop(ITYPE_ALU, ALU_ADD, 0, 0), 5'd5, 5'd5, 5'd6, '0, 0, '0, '0,
                  1'b1, make_uop(ITYPE_ALU, ALU_XOR, 0, 0), 5'd9, 5'd9, 5'd10);
        end
        for (int i = 0; i < 8; i++) begin
            rd0 = 5'd7 + i[0];
            rd1 = 5'd9 + i[0];
            issue(1'b1, make_uop(ITYPE_ALU, ALU_SUB, 0, 0), rd0, rd0, 5'd11, '0, 0, '0, '0,
                  1'b1, make_uop(ITYPE_ALU, ALU_ADD, 0, 0), rd1, rd1, 5'd15 - rd0);
        end
        alu0(ALU_ADD, 5'd0, 5'd5, 5'd6);
        alu0(ALU_OR, 5'd15, 5'd0, 5'd6);

        // each branch condition with equal sources and both orders of unequal ones
        foreach (conds[c]) begin
            for (int v = 0; v < 3; v++) begin
                ra  = (v == 2) ? 5'd4 : 5'd3;
                rb  = (v == 1) ? 5'd4 : 5'd3;
                pc  = $random(seed) & 32'h0000_fffc;
                imm = ($random(seed) & 32'h3fc) - 32'h200;
                issue(1'b1, make_uop(ITYPE_BR, conds[c], 0, 0), rb, ra, 5'd0, imm, 1'b0, pc,
                      (v == 1) ? pc + imm : pc + 32'd4, 1'b0, '0, '0, '0, '0);
            end
        end

        // corner values through the immediate path
        for (int i = 0; i < 5; i++) begin
            issue(1'b1, make_uop(ITYPE_ALU, ALU_LUI, 0, 0), 5'd20 + i, 5'd0, 5'd0, corners[i],
                  1'b1, '0, '0, 1'b0, '0, '0, '0, '0);
        end

        // multiply then an immediate consumer
        for (int p = 0; p < 5; p++) begin
            for (int v = 0; v < 4; v++) begin
                issue(1'b1, make_uop(ITYPE_MUL, 0, v[0], v[1]), 5'd25, ma[p], mb[p], '0, 0,
                      '0, '0, 1'b0, '0, '0, '0, '0);
                alu0(ALU_ADD, 5'd26, 5'd25, 5'd20);
            end
        end

        // divide then a consumer
        for (int p = 0; p < 5; p++) begin
            for (int v = 0; v < 4; v++) begin
                issue(1'b1, make_uop(ITYPE_DIV, 0, v[0], v[1]), 5'd27, da[p], db[p], '0, 0,
                      '0, '0, 1'b0, '0, '0, '0, '0);
                alu0(ALU_XOR, 5'd28, 5'd27, 5'd21);
            end
        end

        @(negedge clk);
        eu0_en = 1'b0;
        eu1_en = 1'b0;
        while (q0.size() != 0 || q1.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);

        $display("checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: hdl/exe.sv
`timescale 1ns/1ns
module exe (
    input  logic               clk,
    input  logic               rstn,
    input  logic               eu0_en,
    input  exe_pkg::uop_t      eu0_uop,
    input  exe_pkg::reg_addr_t eu0_rd,
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::word_t     eu0_imm,
    input  exe_pkg::word_t     eu0_pc,
    input  exe_pkg::word_t     eu0_pc_next,
    input  exe_pkg::word_t     data00,
    input  exe_pkg::word_t     data01,
    input  logic               eu1_en,
    input  exe_pkg::uop_t      eu1_uop,
    input  exe_pkg::reg_addr_t eu1_rd,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  exe_pkg::word_t     data10,
    input  exe_pkg::word_t     data11,
    output logic               stall,
    output logic               flush,
    output logic               branch_valid,
    output exe_pkg::word_t     branch_pc,
    output exe_pkg::word_t     branch_target,
    output logic               branch_taken,
    output logic               en_out0,
    output exe_pkg::reg_addr_t addr_out0,
    output exe_pkg::word_t     data_out0,
    output logic               en_out1,
    output exe_pkg::reg_addr_t addr_out1,
    output exe_pkg::word_t     data_out1
);
    import exe_pkg::*;

    mul_stage_if mid ();

    itype_t    eu0_type;
    br_cond_t  eu0_cond;
    logic      eu0_alu_en;
    logic      eu0_br_en;
    logic      eu0_mul_en;
    logic      eu0_div_en;
    logic      eu1_alu_en;

    word_t     eu0_sr0;
    word_t     eu0_sr1;
    word_t     eu1_sr0;
    word_t     eu1_sr1;
    word_t     alu0_result;
    word_t     alu1_result;

    logic      br_taken;
    logic      br_flush;
    logic      link_en;
    word_t     link_data;

    logic      mul_en;
    reg_addr_t mul_rd;
    word_t     mul_result;
    logic      div_busy;
    logic      div_done;
    reg_addr_t div_rd;
    word_t     div_result;

    logic      s1_en0;
    reg_addr_t s1_rd0;
    word_t     s1_data0;
    logic      s1_en1;
    reg_addr_t s1_rd1;
    word_t     s1_data1;

    logic      en_next0;
    reg_addr_t addr_next0;
    word_t     data_next0;

    assign eu0_type   = uop_type(eu0_uop);
    assign eu0_cond   = uop_func(eu0_uop);
    assign eu0_alu_en = eu0_en && eu0_type == ITYPE_ALU;
    assign eu0_br_en  = eu0_en && eu0_type == ITYPE_BR;
    assign eu0_mul_en = eu0_en && eu0_type == ITYPE_MUL;
    assign eu0_div_en = eu0_en && eu0_type == ITYPE_DIV;
    assign eu1_alu_en = eu1_en && uop_type(eu1_uop) == ITYPE_ALU;

    // reported only in the accepted cycle
    assign branch_valid = eu0_br_en && !stall;
    assign branch_taken = br_taken && !stall;
    assign flush        = br_flush && !stall;
    assign branch_pc    = eu0_pc;

    forward_unit forward_inst (
        .eu0_rj   (eu0_rj),
        .eu0_rk   (eu0_rk),
        .eu1_rj   (eu1_rj),
        .eu1_rk   (eu1_rk),
        .eu0_rd   (eu0_rd),
        .eu0_uop  (eu0_uop),
        .data00   (data00),
        .data01   (data01),
        .data10   (data10),
        .data11   (data11),
        .s1_en0   (s1_en0),
        .s1_rd0   (s1_rd0),
        .s1_data0 (s1_data0),
        .s1_mul0  (mid.en),
        .s1_en1   (s1_en1),
        .s1_rd1   (s1_rd1),
        .s1_data1 (s1_data1),
        .o_en0    (en_out0),
        .o_rd0    (addr_out0),
        .o_data0  (data_out0),
        .o_en1    (en_out1),
        .o_rd1    (addr_out1),
        .o_data1  (data_out1),
        .div_busy (div_busy),
        .eu0_sr0  (eu0_sr0),
        .eu0_sr1  (eu0_sr1),
        .eu1_sr0  (eu1_sr0),
        .eu1_sr1  (eu1_sr1),
        .stall    (stall)
    );

    alu alu0_inst (
        .op     (uop_func(eu0_uop)),
        .a      (eu0_sr0),
        .b      (eu0_sr1),
        .result (alu0_result)
    );

    alu alu1_inst (
        .op     (uop_func(eu1_uop)),
        .a      (eu1_sr0),
        .b      (eu1_sr1),
        .result (alu1_result)
    );

    branch_unit branch_inst (
        .en        (eu0_br_en),
        .cond      (eu0_cond),
        .pc        (eu0_pc),
        .pc_next   (eu0_pc_next),
        .imm       (eu0_imm),
        .sr0       (eu0_sr0),
        .sr1       (eu0_sr1),
        .taken     (br_taken),
        .link_en   (link_en),
        .link_data (link_data),
        .target    (branch_target),
        .flush     (br_flush)
    );

    mul_front mul_front_inst (
        .clk   (clk),
        .rstn  (rstn),
        .stall (stall),
        .en    (eu0_mul_en),
        .usign (eu0_uop[UOP_USIGN]),
        .sel   (eu0_uop[UOP_MD_SEL]),
        .rd    (eu0_rd),
        .sr0   (eu0_sr0),
        .sr1   (eu0_sr1),
        .mid   (mid.front)
    );

    mul_back mul_back_inst (
        .mid    (mid.back),
        .en     (mul_en),
        .rd     (mul_rd),
        .result (mul_result)
    );

    divider divider_inst (
        .clk    (clk),
        .rstn   (rstn),
        .start  (eu0_div_en && !stall),
        .usign  (eu0_uop[UOP_USIGN]),
        .sel    (eu0_uop[UOP_MD_SEL]),
        .rd     (eu0_rd),
        .sr0    (eu0_sr0),
        .sr1    (eu0_sr1),
        .busy   (div_busy),
        .done   (div_done),
        .rd_out (div_rd),
        .result (div_result)
    );

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_en0 <= 1'b0;
            s1_en1 <= 1'b0;
        end else begin
            s1_en0 <= !stall && (eu0_alu_en || link_en);
            s1_en1 <= !stall && eu1_alu_en;
        end
    end

    // s1_rd0 also tracks the mul in the front half
    always_ff @(posedge clk) begin
        if (!stall) begin
            s1_rd0   <= (link_en && eu0_cond == BL) ? 5'd1 : eu0_rd;
            s1_data0 <= link_en ? link_data : alu0_result;
            s1_rd1   <= eu1_rd;
            s1_data1 <= alu1_result;
        end
    end

    // lane 0 merge, sources never overlap in time
    always_comb begin
        if (div_done) begin
            addr_next0 = div_rd;
            data_next0 = div_result;
        end else if (mul_en) begin
            addr_next0 = mul_rd;
            data_next0 = mul_result;
        end else begin
            addr_next0 = s1_rd0;
            data_next0 = s1_data0;
        end
    end

    assign en_next0 = s1_en0 || mul_en || div_done;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
        end else begin
            en_out0 <= en_next0 && addr_next0 != '0;   // r0 writes dropped
            en_out1 <= s1_en1 && s1_rd1 != '0;
        end
    end

    always_ff @(posedge clk) begin
        addr_out0 <= addr_next0;
        data_out0 <= data_next0;
        addr_out1 <= s1_rd1;
        data_out1 <= s1_data1;
    end

endmodule

// File: hdl/forward_unit.sv
`timescale 1ns/1ns
module forward_unit (
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  exe_pkg::reg_addr_t eu0_rd,
    input  exe_pkg::uop_t      eu0_uop,
    input  exe_pkg::word_t     data00,
    input  exe_pkg::word_t     data01,
    input  exe_pkg::word_t     data10,
    input  exe_pkg::word_t     data11,
    input  logic               s1_en0,
    input  exe_pkg::reg_addr_t s1_rd0,
    input  exe_pkg::word_t     s1_data0,
    input  logic               s1_mul0,
    input  logic               s1_en1,
    input  exe_pkg::reg_addr_t s1_rd1,
    input  exe_pkg::word_t     s1_data1,
    input  logic               o_en0,
    input  exe_pkg::reg_addr_t o_rd0,
    input  exe_pkg::word_t     o_data0,
    input  logic               o_en1,
    input  exe_pkg::reg_addr_t o_rd1,
    input  exe_pkg::word_t     o_data1,
    input  logic               div_busy,
    output exe_pkg::word_t     eu0_sr0,
    output exe_pkg::word_t     eu0_sr1,
    output exe_pkg::word_t     eu1_sr0,
    output exe_pkg::word_t     eu1_sr1,
    output logic               stall
);
    import exe_pkg::*;

    reg_addr_t eu0_src1;

    // youngest producer wins
    function automatic word_t bypass(reg_addr_t src, word_t rf_val);
        word_t val;
        val = rf_val;
        if (src != '0) begin
            if (s1_en1 && s1_rd1 == src) begin
                val = s1_data1;
            end else if (s1_en0 && s1_rd0 == src) begin
                val = s1_data0;
            end else if (o_en1 && o_rd1 == src) begin
                val = o_data1;
            end else if (o_en0 && o_rd0 == src) begin
                val = o_data0;
            end
        end
        return val;
    endfunction

    // mul result not out of the back half yet
    function automatic logic mul_hit(reg_addr_t src);
        return s1_mul0 && src != '0 && s1_rd0 == src;
    endfunction

    // branches compare rj against rd
    assign eu0_src1 = (uop_type(eu0_uop) == ITYPE_BR) ? eu0_rd : eu0_rk;

    always_comb begin
        eu0_sr0 = bypass(eu0_rj, data00);
        eu0_sr1 = bypass(eu0_src1, data01);
        eu1_sr0 = bypass(eu1_rj, data10);
        eu1_sr1 = bypass(eu1_rk, data11);
    end

    always_comb begin
        stall = div_busy || mul_hit(eu0_rj) || mul_hit(eu0_src1)
                || mul_hit(eu1_rj) || mul_hit(eu1_rk);
    end

endmodule

// File: hdl/divider.sv
`timescale 1ns/1ns
module divider (
    input  logic               clk,
    input  logic               rstn,
    input  logic               start,
    input  logic               usign,
    input  logic               sel,
    input  exe_pkg::reg_addr_t rd,
    input  exe_pkg::word_t     sr0,
    input  exe_pkg::word_t     sr1,
    output logic               busy,
    output logic               done,
    output exe_pkg::reg_addr_t rd_out,
    output exe_pkg::word_t     result
);
    import exe_pkg::*;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_FIX
    } div_state_t;

    div_state_t  state;
    logic [4:0]  step;
    word_t       rem;
    word_t       quo;       // dividend shifts out as quotient shifts in
    word_t       dsr;
    logic        q_neg;
    logic        r_neg;
    logic        sel_q;
    reg_addr_t   rd_q;
    logic        a_neg;
    logic        b_neg;
    logic [32:0] trial;
    logic [32:0] diff;

    assign a_neg = !usign && sr0[31];
    assign b_neg = !usign && sr1[31];
    assign trial = {rem, quo[31]};
    assign diff  = trial - {1'b0, dsr};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= DIV_IDLE;
            step  <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    step <= '0;
                    if (start) begin
                        state <= DIV_RUN;
                    end
                end
                DIV_RUN: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) begin
                        state <= DIV_FIX;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            rem   <= '0;
            quo   <= a_neg ? -sr0 : sr0;
            dsr   <= b_neg ? -sr1 : sr1;
            // x/0 keeps an all-ones quotient
            q_neg <= (a_neg ^ b_neg) && (sr1 != '0);
            r_neg <= a_neg;
            sel_q <= sel;
            rd_q  <= rd;
        end else if (state == DIV_RUN) begin
            if (!diff[32]) begin
                rem <= diff[31:0];
                quo <= {quo[30:0], 1'b1};
            end else begin
                rem <= trial[31:0];
                quo <= {quo[30:0], 1'b0};
            end
        end
    end

    assign busy   = state != DIV_IDLE;
    assign done   = state == DIV_FIX;
    assign rd_out = rd_q;
    assign result = sel_q ? (r_neg ? -rem : rem) : (q_neg ? -quo : quo);

endmodule

// File: hdl/mul_back.sv
`timescale 1ns/1ns
module mul_back (
    mul_stage_if.back          mid,
    output logic               en,
    output exe_pkg::reg_addr_t rd,
    output exe_pkg::word_t     result
);
    import exe_pkg::*;

    logic [63:0] product;

    // sign-extended sum, wraps mod 2^64
    assign product = 64'($signed(mid.pp0))
                   + (64'($signed(mid.pp1)) << 16)
                   + (64'($signed(mid.pp2)) << 16)
                   + (64'($signed(mid.pp3)) << 32);

    assign result = mid.sel ? product[63:32] : product[31:0];
    assign en     = mid.en;
    assign rd     = mid.rd;

endmodule

// File: hdl/mul_front.sv
`timescale 1ns/1ns
module mul_front (
    input  logic               clk,
    input  logic               rstn,
    input  logic               stall,
    input  logic               en,
    input  logic               usign,
    input  logic               sel,
    input  exe_pkg::reg_addr_t rd,
    input  exe_pkg::word_t     sr0,
    input  exe_pkg::word_t     sr1,
    mul_stage_if.front         mid
);
    import exe_pkg::*;

    logic [32:0]        a_ext;
    logic [32:0]        b_ext;
    logic signed [16:0] a_lo;
    logic signed [16:0] a_hi;
    logic signed [16:0] b_lo;
    logic signed [16:0] b_hi;

    assign a_ext = {!usign && sr0[31], sr0};
    assign b_ext = {!usign && sr1[31], sr1};

    // low halves are unsigned, high halves carry the sign
    assign a_lo = {1'b0, a_ext[15:0]};
    assign b_lo = {1'b0, b_ext[15:0]};
    assign a_hi = a_ext[32:16];
    assign b_hi = b_ext[32:16];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mid.en <= 1'b0;
        end else begin
            mid.en <= en && !stall;    // bubble while stalled
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mid.rd  <= rd;
            mid.sel <= sel;
            mid.pp0 <= a_lo * b_lo;
            mid.pp1 <= a_lo * b_hi;
            mid.pp2 <= a_hi * b_lo;
            mid.pp3 <= a_hi * b_hi;
        end
    end

endmodule

// File: hdl/branch_unit.sv
`timescale 1ns/1ns
module branch_unit (
    input  logic              en,
    input  exe_pkg::br_cond_t cond,
    input  exe_pkg::word_t    pc,
    input  exe_pkg::word_t    pc_next,
    input  exe_pkg::word_t    imm,
    input  exe_pkg::word_t    sr0,
    input  exe_pkg::word_t    sr1,
    output logic              taken,
    output logic              link_en,
    output exe_pkg::word_t    link_data,
    output exe_pkg::word_t    target,
    output logic              flush
);
    import exe_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond_true;

    assign eq   = sr0 == sr1;
    assign lt_s = $signed(sr0) < $signed(sr1);
    assign lt_u = sr0 < sr1;

    always_comb begin
        case (cond)
            JIRL, B, BL: cond_true = 1'b1;
            BEQ:         cond_true = eq;
            BNE:         cond_true = !eq;
            BLT:         cond_true = lt_s;
            BGE:         cond_true = !lt_s;
            BLTU:        cond_true = lt_u;
            BGEU:        cond_true = !lt_u;
            default:     cond_true = 1'b0;
        endcase
    end

    assign taken  = en && cond_true;
    assign target = (cond == JIRL) ? sr0 + imm : pc + imm;

    // return address for calls
    assign link_en   = en && (cond == BL || cond == JIRL);
    assign link_data = pc + 32'd4;

    assign flush = taken && (target != pc_next);   // fetch went the wrong way

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ns
module alu (
    input  exe_pkg::alu_op_t op,
    input  exe_pkg::word_t   a,
    input  exe_pkg::word_t   b,
    output exe_pkg::word_t   result
);
    import exe_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLT:  result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'd0, a < b};
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_LUI:  result = b;    // upper immediate prepared by issuer
            default:  result = '0;
        endcase
    end

endmodule

// File: hdl/mul_stage_if.sv
`timescale 1ns/1ns
interface mul_stage_if;
    import exe_pkg::*;

    logic      en;
    reg_addr_t rd;
    logic      sel;    // 1 selects high word
    pp_t       pp0;    // a_lo * b_lo
    pp_t       pp1;    // a_lo * b_hi
    pp_t       pp2;    // a_hi * b_lo
    pp_t       pp3;    // a_hi * b_hi

    modport front (output en, rd, sel, pp0, pp1, pp2, pp3);
    modport back  (input en, rd, sel, pp0, pp1, pp2, pp3);

endinterface

// File: hdl/exe_pkg.sv
package exe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] uop_t;
    typedef logic [2:0]  itype_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [3:0]  br_cond_t;
    typedef logic [33:0] pp_t;     // one 17x17 signed product

    // uop field positions, bits 11:9 spare
    localparam int UOP_TYPE_LSB = 0;
    localparam int UOP_FUNC_LSB = 3;
    localparam int UOP_MD_SEL   = 7;   // mul high word / div remainder
    localparam int UOP_USIGN    = 8;

    localparam itype_t ITYPE_ALU = 3'd0;
    localparam itype_t ITYPE_BR  = 3'd1;
    localparam itype_t ITYPE_MUL = 3'd2;
    localparam itype_t ITYPE_DIV = 3'd3;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLT  = 4'd2;
    localparam alu_op_t ALU_SLTU = 4'd3;
    localparam alu_op_t ALU_AND  = 4'd4;
    localparam alu_op_t ALU_OR   = 4'd5;
    localparam alu_op_t ALU_XOR  = 4'd6;
    localparam alu_op_t ALU_NOR  = 4'd7;
    localparam alu_op_t ALU_SLL  = 4'd8;
    localparam alu_op_t ALU_SRL  = 4'd9;
    localparam alu_op_t ALU_SRA  = 4'd10;
    localparam alu_op_t ALU_LUI  = 4'd11;

    localparam br_cond_t JIRL = 4'd3;
    localparam br_cond_t B    = 4'd4;
    localparam br_cond_t BL   = 4'd5;
    localparam br_cond_t BEQ  = 4'd6;
    localparam br_cond_t BNE  = 4'd7;
    localparam br_cond_t BLT  = 4'd8;
    localparam br_cond_t BGE  = 4'd9;
    localparam br_cond_t BLTU = 4'd10;
    localparam br_cond_t BGEU = 4'd11;

    function automatic itype_t uop_type(uop_t uop);
        return uop[UOP_TYPE_LSB +: 3];
    endfunction

    // alu op or branch condition
    function automatic alu_op_t uop_func(uop_t uop);
        return uop[UOP_FUNC_LSB +: 4];
    endfunction

endpackage
